/* Makefile */
# Verilator build and run for the branch recovery testbench.

TOP := tb_br_recovery

.PHONY: all lint clean

all:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f build.f
	@out=$$(./obj_dir/V$(TOP)); echo "$$out"; \
	echo "$$out" | grep -qx "Simulation finished: PASS"

lint:
	verilator --lint-only --timing --top-module $(TOP) -f build.f

clean:
	rm -rf obj_dir

/* br_mask_ctrl.sv */
// Branch mask controller.
// Hands out mask bits, clears them on resolve and runs the one-cycle recovery FSM.
`timescale 1ns/100ps
`default_nettype none

module br_mask_ctrl #(
	parameter int NUM_BR = 4
) (
	input  wire logic                          clk,
	input  wire logic                          rst,
	input  wire logic                          disp_i,
	input  wire branch_pkg::br_resolve_t       resolve_i,
	input  wire logic [NUM_BR-1:0][NUM_BR-1:0] rc_masks_i,
	output logic [NUM_BR-1:0]                  mask_o,
	output logic [NUM_BR-1:0]                  next_mask_o,
	output logic [NUM_BR-1:0]                  alloc_o,
	output logic                               restore_o,
	output logic [NUM_BR-1:0]                  restore_sel_o,
	output logic                               stall_o
);

	import branch_pkg::*;

	br_state_t state_q;
	br_state_t state_d;

	// Live mask and its next value.
	logic [NUM_BR-1:0] mask_q;
	logic [NUM_BR-1:0] mask_d;

	// Resolve decode.
	logic [NUM_BR-1:0] res_tag;
	logic              res_ok;
	logic              res_bad;

	// Mask after a correct clear, and the saved mask of the resolving branch.
	logic [NUM_BR-1:0] cleared;
	logic [NUM_BR-1:0] saved_mask;

	assign res_tag = resolve_i.tag[NUM_BR-1:0];
	assign res_ok  = resolve_i.valid && resolve_i.correct;
	assign res_bad = resolve_i.valid && !resolve_i.correct;

	// A correct resolve frees its bit in the same cycle.
	// A dispatch alongside it may take that bit.
	assign cleared = res_ok ? (mask_q & ~res_tag) : mask_q;

	// Lowest 0 bit of the cleared mask.
	// Comes out as 0 when the mask is full.
	assign alloc_o = ~cleared & (cleared + 1'b1);

	// One-hot pick of the saved mask.
	always_comb begin
		saved_mask = '0;
		for (int i = 0; i < NUM_BR; i++) begin
			if (res_tag[i]) begin
				saved_mask = saved_mask | rc_masks_i[i];
			end
		end
	end

	// Next mask and FSM state.
	// Mispredict drops the branch's own bit from its saved mask.
	// Younger branches were never in that mask, so they go too.
	always_comb begin
		mask_d  = cleared;
		state_d = BR_IDLE;
		if (res_bad) begin
			mask_d  = saved_mask & ~res_tag;
			state_d = BR_RECOVER;
		end else if (disp_i) begin
			mask_d = cleared | alloc_o;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			mask_q  <= '0;
			state_q <= BR_IDLE;
		end else begin
			mask_q  <= mask_d;
			state_q <= state_d;
		end
	end

	assign mask_o      = mask_q;
	assign next_mask_o = mask_d;

	// Restore pulse and entry select, both in the resolve-wrong cycle.
	assign restore_o     = res_bad;
	assign restore_sel_o = res_tag;

	// Full mask or recovery bubble.
	assign stall_o = (&mask_q) || (state_q == BR_RECOVER);

	// Resolves must name exactly one pending branch.
	assert property (@(posedge clk) disable iff (rst)
		resolve_i.valid |-> $onehot(resolve_i.tag)
			&& ((resolve_i.tag & BR_MAX'(mask_q)) != '0))
		else $error("br_mask_ctrl: resolve tag not one-hot or not pending");

	// With stall up the top blocks dispatch, so only a resolve moves the mask.
	assert property (@(posedge clk) disable iff (rst)
		(stall_o && !resolve_i.valid) |=> $stable(mask_q))
		else $error("br_mask_ctrl: mask changed while stalled");

endmodule

`default_nettype wire

/* br_recovery_top.sv */
// Branch recovery top level.
// Ties the mask controller and the stack entries to the map table and head counter.
`timescale 1ns/100ps
`default_nettype none

module br_recovery_top #(
	parameter int NUM_BR = 4
) (
	input  wire logic                    clk,
	input  wire logic                    rst,
	input  wire logic                    rn_valid_i,
	input  wire rename_pkg::arch_reg_t   rn_arch_i,
	input  wire rename_pkg::arch_reg_t   lk_arch_i,
	input  wire logic                    br_disp_i,
	input  wire branch_pkg::br_resolve_t br_resolve_i,
	output rename_pkg::phys_tag_t        rn_tag_o,
	output rename_pkg::phys_tag_t        lk_tag_o,
	output logic [NUM_BR-1:0]            br_tag_o,
	output logic [NUM_BR-1:0]            br_mask_o,
	output logic                         stall_o
);

	import rename_pkg::*;

	// Mask controller outputs.
	logic [NUM_BR-1:0] mask;
	logic [NUM_BR-1:0] next_mask;
	logic [NUM_BR-1:0] restore_sel;
	logic              restore;

	// Per-entry saved state.
	logic [NUM_BR-1:0][NUM_BR-1:0] rc_masks;
	map_snapshot_t [NUM_BR-1:0]    rc_snaps;

	// Next-state snapshot and the one picked for restore.
	map_snapshot_t mt_next;
	map_snapshot_t next_snap;
	map_snapshot_t restore_snap;
	fl_ptr_t       fl_next_head;

	// Gated requests.
	logic rn_ok;
	logic disp_ok;

	// Nothing renames or dispatches while stalled or restoring.
	assign rn_ok   = rn_valid_i && !stall_o && !restore;
	assign disp_ok = br_disp_i && !stall_o && !restore;

	br_mask_ctrl #(.NUM_BR(NUM_BR)) br_mask_ctrl_i (
		.clk           (clk),
		.rst           (rst),
		.disp_i        (disp_ok),
		.resolve_i     (br_resolve_i),
		.rc_masks_i    (rc_masks),
		.mask_o        (mask),
		.next_mask_o   (next_mask),
		.alloc_o       (br_tag_o),
		.restore_o     (restore),
		.restore_sel_o (restore_sel),
		.stall_o       (stall_o)
	);

	// Map from the table, head from the counter.
	assign next_snap.map  = mt_next.map;
	assign next_snap.head = fl_next_head;

	for (genvar g = 0; g < NUM_BR; g++) begin : g_ent
		br_stack_ent #(.NUM_BR(NUM_BR)) br_stack_ent_i (
			.clk        (clk),
			.rst        (rst),
			.mask_bit_i (mask[g]),
			.bak_i      (next_snap),
			.mask_bak_i (next_mask),
			.rc_o       (rc_snaps[g]),
			.rc_mask_o  (rc_masks[g])
		);
	end

	// One-hot mux over the entries.
	always_comb begin
		restore_snap = '0;
		for (int i = 0; i < NUM_BR; i++) begin
			if (restore_sel[i]) begin
				restore_snap = map_snapshot_t'(restore_snap | rc_snaps[i]);
			end
		end
	end

	map_table map_table_i (
		.clk           (clk),
		.rst           (rst),
		.wr_en_i       (rn_ok),
		.wr_arch_i     (rn_arch_i),
		.wr_tag_i      (rn_tag_o),
		.rd_arch_i     (lk_arch_i),
		.rd_tag_o      (lk_tag_o),
		.restore_i     (restore),
		.restore_map_i (restore_snap),
		.next_map_o    (mt_next)
	);

	free_list_head free_list_head_i (
		.clk            (clk),
		.rst            (rst),
		.alloc_i        (rn_ok),
		.restore_i      (restore),
		.restore_head_i (restore_snap.head),
		.tag_o          (rn_tag_o),
		.next_head_o    (fl_next_head)
	);

	assign br_mask_o = mask;

endmodule

`default_nettype wire

/* br_stack_ent.sv */
// One branch checkpoint slot.
// Follows the next-state rename data while free, holds it while its branch is pending.
`timescale 1ns/100ps
`default_nettype none

module br_stack_ent #(
	parameter int NUM_BR = 4
) (
	input  wire logic                      clk,
	input  wire logic                      rst,
	input  wire logic                      mask_bit_i,
	input  wire rename_pkg::map_snapshot_t bak_i,
	input  wire logic [NUM_BR-1:0]         mask_bak_i,
	output rename_pkg::map_snapshot_t      rc_o,
	output logic [NUM_BR-1:0]              rc_mask_o
);

	import rename_pkg::*;

	// Saved rename state and saved branch mask.
	map_snapshot_t     snap_q;
	logic [NUM_BR-1:0] mask_q;

	// Free slot tracks every cycle.
	// The edge that sets our bit is the last copy, so it holds the state after dispatch.
	always_ff @(posedge clk) begin
		if (!mask_bit_i) begin
			snap_q <= bak_i;
		end
	end

	// Saved mask, which includes our own bit once frozen.
	always_ff @(posedge clk) begin
		if (rst) begin
			mask_q <= '0;
		end else if (!mask_bit_i) begin
			mask_q <= mask_bak_i;
		end
	end

	assign rc_o      = snap_q;
	assign rc_mask_o = mask_q;

endmodule

`default_nettype wire

/* branch_pkg.sv */
// Branch tracking types for the mask controller and the recovery FSM.
`default_nettype none

package branch_pkg;

	// Largest supported number of branches in flight.
	// Modules take NUM_BR from 2 up to this value.
	localparam int BR_MAX = 4;

	// Recovery FSM states.
	// BR_RECOVER lasts one cycle after a wrong resolve.
	typedef enum logic {
		BR_IDLE,
		BR_RECOVER
	} br_state_t;

	// One branch resolution from the execute side.
	// Tag is one-hot on the branch's mask bit.
	// Bits at and above NUM_BR must stay 0.
	typedef struct packed {
		logic              valid;
		logic              correct;
		logic [BR_MAX-1:0] tag;
	} br_resolve_t;

endpackage

`default_nettype wire

/* build.f */
rename_pkg.sv
branch_pkg.sv
map_table.sv
free_list_head.sv
br_stack_ent.sv
br_mask_ctrl.sv
br_recovery_top.sv
tb_br_recovery.sv

/* free_list_head.sv */
// Free-list head counter.
// Wraps over the 32-tag ring and can be reloaded from a branch snapshot.
`timescale 1ns/100ps
`default_nettype none

module free_list_head (
	input  wire logic               clk,
	input  wire logic               rst,
	input  wire logic               alloc_i,
	input  wire logic               restore_i,
	input  wire rename_pkg::fl_ptr_t restore_head_i,
	output rename_pkg::phys_tag_t   tag_o,
	output rename_pkg::fl_ptr_t     next_head_o
);

	import rename_pkg::*;

	// Head now and after this edge.
	fl_ptr_t head_q;
	fl_ptr_t head_d;

	// Restore wins over an allocation.
	// Increment wraps at 32 by the 5-bit width.
	always_comb begin
		head_d = head_q;
		if (restore_i) begin
			head_d = restore_head_i;
		end else if (alloc_i) begin
			head_d = head_q + 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			head_q <= '0;
		end else begin
			head_q <= head_d;
		end
	end

	// Tag for a rename in this cycle.
	// Ring base plus the head.
	assign tag_o = FL_BASE + phys_tag_t'(head_q);

	// Post-edge head, copied by the stack entries.
	assign next_head_o = head_d;

endmodule

`default_nettype wire

/* map_table.sv */
// Architectural-to-physical register map.
// Takes one rename write per cycle and can be reloaded whole from a snapshot.
`timescale 1ns/100ps
`default_nettype none

module map_table (
	input  wire logic                     clk,
	input  wire logic                     rst,
	input  wire logic                     wr_en_i,
	input  wire rename_pkg::arch_reg_t    wr_arch_i,
	input  wire rename_pkg::phys_tag_t    wr_tag_i,
	input  wire rename_pkg::arch_reg_t    rd_arch_i,
	output rename_pkg::phys_tag_t         rd_tag_o,
	input  wire logic                     restore_i,
	input  wire rename_pkg::map_snapshot_t restore_map_i,
	output rename_pkg::map_snapshot_t     next_map_o
);

	import rename_pkg::*;

	// Current map and the map after this edge.
	phys_tag_t [NUM_ARCH-1:0] map_q;
	phys_tag_t [NUM_ARCH-1:0] map_d;

	// Next-state map.
	// A restore overrides any write in the same cycle.
	always_comb begin
		map_d = map_q;
		if (restore_i) begin
			map_d = restore_map_i.map;
		end else if (wr_en_i) begin
			map_d[wr_arch_i] = wr_tag_i;
		end
	end

	// Identity map out of reset.
	// Register r starts out on tag r.
	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < NUM_ARCH; i++) begin
				map_q[i] <= phys_tag_t'(i);
			end
		end else begin
			map_q <= map_d;
		end
	end

	// Lookup reads the registered map.
	// A rename shows up here one cycle later.
	assign rd_tag_o = map_q[rd_arch_i];

	// The stack entries back up the post-edge map.
	assign next_map_o.map = map_d;
	// Head is filled in by the free-list counter at the top.
	assign next_map_o.head = '0;

	// The top must hold renames off during a restore cycle.
	assert property (@(posedge clk) disable iff (rst)
		!(restore_i && wr_en_i))
		else $error("map_table: rename write in a restore cycle");

endmodule

`default_nettype wire

/* rename_pkg.sv */
// Rename data types shared by the map table, the free-list counter and the
// branch stack entries.
`default_nettype none

package rename_pkg;

	// Number of architectural registers.
	localparam int NUM_ARCH = 32;

	// First tag of the free ring.
	// The ring holds tags 32 to 63 and hands them out in order.
	localparam logic [6:0] FL_BASE = 7'd32;

	// Architectural register index.
	typedef logic [4:0] arch_reg_t;

	// Physical register tag.
	typedef logic [6:0] phys_tag_t;

	// Free-list head position.
	// It wraps at 32, the size of the ring.
	typedef logic [4:0] fl_ptr_t;

	// Full rename state at one point in time.
	// Taken by each stack entry when its branch is dispatched.
	// Loaded back into the map table and the counter on a mispredict.
	// Map field is 32 x 7 = 224 bits, head adds 5, 229 in total.
	typedef struct packed {
		phys_tag_t [NUM_ARCH-1:0] map;
		fl_ptr_t                  head;
	} map_snapshot_t;

endpackage

`default_nettype wire

/* tb_br_recovery.sv */
// Self-checking testbench for the branch recovery top level.
// A reference model follows rename, dispatch and resolve, and assertions compare the DUT to it.
`timescale 1ns/100ps
`default_nettype none

module tb_br_recovery;

	import rename_pkg::*;
	import branch_pkg::*;

	localparam int NUM_BR = 4;
	localparam int CYCLE_LIMIT = 600;
	localparam logic [NUM_BR-1:0] FULL = '1;
	localparam logic [NUM_BR-1:0] ONE = NUM_BR'(1);
	localparam br_resolve_t NO_RES = '0;

	logic clk;
	logic rst;
	logic rn_valid;
	arch_reg_t rn_arch;
	arch_reg_t lk_arch;
	logic br_disp;
	br_resolve_t br_res;
	phys_tag_t rn_tag;
	phys_tag_t lk_tag;
	logic [NUM_BR-1:0] br_tag;
	logic [NUM_BR-1:0] br_mask;
	logic stall;

	int seed = 22;
	int cycles = 0;
	int test_no = 0;
	int value_errors = 0;
	int other_errors = 0;

	// Model state for the current cycle.
	phys_tag_t m_map [NUM_ARCH];
	fl_ptr_t m_head;
	logic [NUM_BR-1:0] m_mask;
	logic m_rec;
	// Checkpoints, one per mask bit.
	phys_tag_t s_map [NUM_BR][NUM_ARCH];
	fl_ptr_t s_head [NUM_BR];
	logic [NUM_BR-1:0] s_mask [NUM_BR];
	// Model state after the coming edge.
	phys_tag_t n_map [NUM_ARCH];
	fl_ptr_t n_head;
	logic [NUM_BR-1:0] n_mask;
	logic n_rec;

	// Expected outputs of this cycle.
	logic [NUM_BR-1:0] exp_clear;
	logic [NUM_BR-1:0] exp_br_tag;
	logic exp_stall;
	br_state_t exp_state;
	phys_tag_t exp_rn_tag;
	phys_tag_t exp_lk_tag;
	logic wrong_res;
	int res_idx;

	br_recovery_top #(.NUM_BR(NUM_BR)) br_recovery_top_i (
		.clk          (clk),
		.rst          (rst),
		.rn_valid_i   (rn_valid),
		.rn_arch_i    (rn_arch),
		.lk_arch_i    (lk_arch),
		.br_disp_i    (br_disp),
		.br_resolve_i (br_res),
		.rn_tag_o     (rn_tag),
		.lk_tag_o     (lk_tag),
		.br_tag_o     (br_tag),
		.br_mask_o    (br_mask),
		.stall_o      (stall)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	// Lowest clear bit as a one-hot, zero when every bit is set.
	function automatic logic [NUM_BR-1:0] lowest_free(input logic [NUM_BR-1:0] m);
		logic [NUM_BR-1:0] r;
		r = '0;
		for (int i = NUM_BR - 1; i >= 0; i--) begin
			if (!m[i]) r = ONE << i;
		end
		return r;
	endfunction

	function automatic int tag_index(input logic [NUM_BR-1:0] t);
		int idx;
		idx = 0;
		for (int i = 0; i < NUM_BR; i++) begin
			if (t[i]) idx = i;
		end
		return idx;
	endfunction

	function automatic string test_name(input int n);
		case (n)
			1: return "reset";
			2: return "rename";
			3: return "dispatch";
			4: return "correct_resolve";
			5: return "wrong_resolve";
			6: return "random";
			default: return "idle";
		endcase
	endfunction

	function automatic br_resolve_t make_res(input logic correct, input logic [NUM_BR-1:0] sel);
		br_resolve_t r;
		r.valid = 1'b1;
		r.correct = correct;
		r.tag = BR_MAX'(sel);
		return r;
	endfunction

	task automatic report_mismatch(input string check, input int n, input int exp, input int act);
		value_errors++;
		$display("FAIL %s/%s: expected %0d, actual %0d", test_name(n), check, exp, act);
	endtask

	// Stall comes from a full mask or the bubble after a mispredict.
	assign exp_stall = (m_mask == FULL) || m_rec;
	// FSM sits in recovery only during the bubble.
	assign exp_state = m_rec ? BR_RECOVER : BR_IDLE;
	assign wrong_res = br_res.valid && !br_res.correct;
	assign exp_clear = (br_res.valid && br_res.correct) ? (m_mask & ~br_res.tag[NUM_BR-1:0])
		: m_mask;
	assign exp_br_tag = lowest_free(exp_clear);
	// Ring of tags 32 to 63 in order.
	assign exp_rn_tag = 7'd32 + {2'b00, m_head};
	assign exp_lk_tag = m_map[lk_arch];
	assign res_idx = tag_index(br_res.tag[NUM_BR-1:0]);

	// Next model state.
	// A mispredict reloads the checkpoint and ignores rename and dispatch.
	always_comb begin
		n_map = m_map;
		n_head = m_head;
		n_mask = exp_clear;
		n_rec = 1'b0;
		if (wrong_res) begin
			for (int r = 0; r < NUM_ARCH; r++) begin
				n_map[r] = s_map[res_idx][r];
			end
			n_head = s_head[res_idx];
			n_mask = s_mask[res_idx] & ~br_res.tag[NUM_BR-1:0];
			n_rec = 1'b1;
		end else begin
			if (rn_valid && !exp_stall) begin
				n_map[rn_arch] = exp_rn_tag;
				n_head = m_head + 5'd1;
			end
			if (br_disp && !exp_stall) n_mask = exp_clear | exp_br_tag;
		end
	end

	// Checkpoints follow the next state while their bit is clear.
	always_ff @(posedge clk) begin
		if (rst) begin
			for (int r = 0; r < NUM_ARCH; r++) begin
				m_map[r] <= phys_tag_t'(r);
			end
			m_head <= '0;
			m_mask <= '0;
			m_rec <= 1'b0;
		end else begin
			m_map <= n_map;
			m_head <= n_head;
			m_mask <= n_mask;
			m_rec <= n_rec;
			for (int i = 0; i < NUM_BR; i++) begin
				if (!m_mask[i]) begin
					s_map[i] <= n_map;
					s_head[i] <= n_head;
					s_mask[i] <= n_mask;
				end
			end
		end
	end

	assert property (@(posedge clk) disable iff (rst) rn_tag == exp_rn_tag)
		else report_mismatch("rename_tag", $sampled(test_no), int'($sampled(exp_rn_tag)),
			int'($sampled(rn_tag)));
	assert property (@(posedge clk) disable iff (rst) lk_tag == exp_lk_tag)
		else report_mismatch("lookup_tag", $sampled(test_no), int'($sampled(exp_lk_tag)),
			int'($sampled(lk_tag)));
	assert property (@(posedge clk) disable iff (rst) br_mask == m_mask)
		else report_mismatch("branch_mask", $sampled(test_no), int'($sampled(m_mask)),
			int'($sampled(br_mask)));
	assert property (@(posedge clk) disable iff (rst) br_tag == exp_br_tag)
		else report_mismatch("branch_tag", $sampled(test_no), int'($sampled(exp_br_tag)),
			int'($sampled(br_tag)));
	assert property (@(posedge clk) disable iff (rst) stall == exp_stall)
		else report_mismatch("stall", $sampled(test_no), int'($sampled(exp_stall)),
			int'($sampled(stall)));
	assert property (@(posedge clk) disable iff (rst)
		br_recovery_top_i.br_mask_ctrl_i.state_q == exp_state)
		else report_mismatch("fsm_state", $sampled(test_no), int'($sampled(exp_state)),
			int'($sampled(br_recovery_top_i.br_mask_ctrl_i.state_q)));

	// Bubble is exactly one cycle long.
	assert property (@(posedge clk) disable iff (rst) $past(wrong_res) |-> stall)
		else begin
			other_errors++;
			$display("Stall was not raised in the cycle after a mispredict");
		end
	assert property (@(posedge clk) disable iff (rst)
		($past(wrong_res, 2) && !$past(wrong_res)) |-> !stall)
		else begin
			other_errors++;
			$display("Stall stayed high for more than one cycle after a mispredict");
		end

	task automatic drive_cycle(input logic rv, input arch_reg_t ra, input arch_reg_t la,
		input logic d, input br_resolve_t rs);
		@(posedge clk);
		rn_valid <= rv;
		rn_arch <= ra;
		lk_arch <= la;
		br_disp <= d;
		br_res <= rs;
	endtask

	// One random cycle, decided from the model state of the cycle it drives.
	task automatic drive_random();
		logic [31:0] r;
		logic stalled;
		logic wrong;
		logic [NUM_BR-1:0] lo;
		logic [NUM_BR-1:0] hi;
		logic [NUM_BR-1:0] pick;
		int start;
		@(posedge clk);
		r = $random(seed);
		stalled = (n_mask == FULL) || n_rec;
		start = int'(r[5:4]);
		lo = '0;
		hi = '0;
		// Pending bit at or above start, else the lowest pending one.
		for (int k = NUM_BR - 1; k >= 0; k--) begin
			if (n_mask[k]) begin
				lo = ONE << k;
				if (k >= start) hi = ONE << k;
			end
		end
		pick = (hi != '0) ? hi : lo;
		if (n_rec || r[3:0] >= 4'd4) pick = '0;
		wrong = (pick != '0) && !r[6] && !r[7];
		rn_valid <= !stalled && !wrong && r[8];
		rn_arch <= r[13:9];
		lk_arch <= r[18:14];
		br_disp <= !stalled && !wrong && r[19] && r[20];
		br_res <= (pick != '0) ? make_res(!wrong, pick) : NO_RES;
	endtask

	initial begin
		arch_reg_t prev;
		rst <= 1'b1;
		rn_valid <= 1'b0;
		rn_arch <= '0;
		lk_arch <= '0;
		br_disp <= 1'b0;
		br_res <= NO_RES;
		repeat (2) @(posedge clk);
		rst <= 1'b0;

		// Identity map, empty mask, first tag 32.
		test_no = 1;
		for (int r = 0; r < NUM_ARCH; r++) begin
			drive_cycle(1'b0, '0, arch_reg_t'(r), 1'b0, NO_RES);
		end

		// Renames past the ring wrap, each looked up one cycle later.
		test_no = 2;
		prev = '0;
		for (int i = 0; i < 40; i++) begin
			drive_cycle(1'b1, arch_reg_t'((i * 5) % 11), prev, 1'b0, NO_RES);
			prev = arch_reg_t'((i * 5) % 11);
		end

		// Four dispatches fill the mask, the fifth is dropped.
		test_no = 3;
		for (int k = 0; k < 5; k++) begin
			drive_cycle(1'b1, arch_reg_t'(k), arch_reg_t'(k), 1'b1, NO_RES);
		end
		drive_cycle(1'b0, '0, '0, 1'b0, NO_RES);

		// Free bit 2, then clear bit 0 and take it back in the same cycle.
		test_no = 4;
		drive_cycle(1'b0, '0, '0, 1'b0, make_res(1'b1, 4'b0100));
		drive_cycle(1'b0, '0, '0, 1'b1, make_res(1'b1, 4'b0001));
		drive_cycle(1'b0, '0, '0, 1'b0, NO_RES);

		// Empty the mask, then three branches with renames between them.
		test_no = 5;
		drive_cycle(1'b0, '0, '0, 1'b0, make_res(1'b1, 4'b0001));
		drive_cycle(1'b0, '0, '0, 1'b0, make_res(1'b1, 4'b0010));
		drive_cycle(1'b0, '0, '0, 1'b0, make_res(1'b1, 4'b1000));
		for (int k = 0; k < 3; k++) begin
			drive_cycle(1'b1, arch_reg_t'(k + 3), '0, 1'b0, NO_RES);
			drive_cycle(1'b1, arch_reg_t'(k + 3), arch_reg_t'(k + 3), 1'b1, NO_RES);
		end
		drive_cycle(1'b1, 5'd5, 5'd4, 1'b0, NO_RES);
		// Middle branch mispredicts, the youngest goes with it.
		drive_cycle(1'b0, '0, 5'd4, 1'b0, make_res(1'b0, 4'b0010));
		for (int r = 0; r < NUM_ARCH; r++) begin
			drive_cycle(1'b0, '0, arch_reg_t'(r), 1'b0, NO_RES);
		end
		drive_cycle(1'b0, '0, '0, 1'b0, make_res(1'b1, 4'b0001));

		test_no = 6;
		repeat (300) drive_random();

		test_no = 0;
		drive_cycle(1'b0, '0, '0, 1'b0, NO_RES);
		repeat (2) @(posedge clk);

		$display("Errors: %0d value mismatches, %0d other failures", value_errors,
			other_errors);
		if (value_errors == 0 && other_errors == 0) begin
			$display("Simulation finished: PASS");
		end else begin
			$display("Simulation finished: FAIL");
		end
		$finish;
	end

	// Run limit.
	initial begin
		while (cycles < CYCLE_LIMIT) begin
			@(posedge clk);
			cycles++;
		end
		$display("Timeout after %0d cycles, tests did not complete", CYCLE_LIMIT);
		$display("Simulation finished: FAIL");
		$finish;
	end

endmodule

`default_nettype wire
